// ==== matrix_logistic.f ====
verilog/logistic_pkg.sv
verilog/matrix_pkg.sv
verilog/tag_if.sv
verilog/matrix_sequencer.sv
verilog/plan_logistic.sv
verilog/result_combiner.sv
verilog/matrix_logistic_top.sv
test/matrix_logistic_assert.sv
test/matrix_logistic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the matrix logistic testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module matrix_logistic_tb \
  -f matrix_logistic.f

# The log decides the result, the simulator status alone does not
./obj_dir/Vmatrix_logistic_tb | tee sim.log

if grep -qx "sim passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== test/matrix_logistic_tb.sv ====
/*
  Testbench for the matrix logistic unit
  PLAN reference model, compare tasks and directed tests
*/

module matrix_logistic_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import logistic_pkg::*;
  import matrix_pkg::*;

  logic CLK;
  logic RST;
  logic start;
  dim_t size_i;
  dim_t size_j;
  logic busy;
  logic in_valid;
  logic in_ready;
  fix_t in_data;
  logic out_valid;
  logic out_ready;
  fix_t out_data;
  dim_t out_row;
  dim_t out_col;
  logic out_row_last;
  logic out_last;
  logic done;

  int   error_count;
  // Elements of the current matrix, row-major
  fix_t stim[$];

  matrix_logistic_top i_dut (.*);

  always #50 CLK = ~CLK;

  ////////////////////
  // Reference and checks
  ////////////////////

  // PLAN on plain integers, division of a non-negative value truncates like a shift
  function automatic fix_t plan_ref(input fix_t x);
    int a;
    int y;
    a = (x < 0) ? -int'(x) : int'(x);
    if (a > 32767) begin
      a = 32767;
    end
    if (a < 4096) begin
      y = a / 4 + 2048;
    end else if (a < 9728) begin
      y = a / 8 + 2560;
    end else if (a < 20480) begin
      y = a / 32 + 3456;
    end else begin
      y = 4096;
    end
    // Mirror around 0.5
    if (x < 0) begin
      y = 4096 - y;
    end
    return fix_t'(y);
  endfunction

  task automatic check_fix(input string name, input fix_t exp, input fix_t act);
    if (exp !== act) begin
      error_count++;
      $display("error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_dim(input string name, input dim_t exp, input dim_t act);
    if (exp !== act) begin
      error_count++;
      $display("error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      error_count++;
      $display("error %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    error_count++;
    $display("%s", msg);
  endtask

  // Outputs of an idle unit
  task automatic check_idle(input string name);
    check_bit({name, " busy"}, 1'b0, busy);
    check_bit({name, " in_ready"}, 1'b0, in_ready);
    check_bit({name, " out_valid"}, 1'b0, out_valid);
    check_bit({name, " done"}, 1'b0, done);
  endtask

  task automatic fill_random(input int n);
    stim.delete();
    repeat (n) begin
      stim.push_back(fix_t'($urandom()));
    end
  endtask

  ////////////////////
  // Matrix run
  ////////////////////

  // Start, stream stim and check every result until done
  task automatic run_matrix(input string name, input dim_t ni, input dim_t nj,
                            input bit random_ready, input bit restart);
    int n;
    int idx_in;
    int idx_out;
    int cycles;
    bit finished;
    n = int'(ni) * int'(nj);
    idx_in = 0;
    idx_out = 0;
    cycles = 0;
    finished = 1'b0;
    @(posedge CLK);
    #10;
    size_i = ni;
    size_j = nj;
    start = 1'b1;
    @(posedge CLK);
    #10;
    start = 1'b0;
    @(negedge CLK);
    check_bit({name, " busy after start"}, 1'b1, busy);
    while (!finished && (cycles < n * 10 + 100)) begin
      @(posedge CLK);
      #10;
      // A start while busy must be ignored
      start = restart && (cycles == 0);
      if (restart && (cycles == 0)) begin
        size_i = dim_t'(int'(ni) + 3);
      end
      in_valid = (idx_in < n);
      if (idx_in < n) begin
        in_data = stim[idx_in];
      end
      out_ready = !random_ready || ($urandom_range(0, 1) == 1);
      @(negedge CLK);
      if (in_valid && in_ready) begin
        idx_in++;
      end
      if (out_valid && out_ready) begin
        if (idx_out >= n) begin
          note_failure({name, ": result after the last element"});
        end else begin
          check_fix({name, " data"}, plan_ref(stim[idx_out]), out_data);
          check_dim({name, " row"}, dim_t'(idx_out / int'(nj)), out_row);
          check_dim({name, " col"}, dim_t'(idx_out % int'(nj)), out_col);
          check_bit({name, " row_last"}, (idx_out % int'(nj)) == int'(nj) - 1, out_row_last);
          check_bit({name, " last"}, idx_out == n - 1, out_last);
        end
        idx_out++;
      end
      if (done) begin
        finished = 1'b1;
        check_bit({name, " busy with done"}, 1'b0, busy);
      end
      cycles++;
    end
    if (!finished) begin
      note_failure({name, ": timed out waiting for done"});
    end
    if (idx_out != n) begin
      note_failure({name, ": number of results differs from number of elements"});
    end
    @(posedge CLK);
    #10;
    start = 1'b0;
    in_valid = 1'b0;
    out_ready = 1'b1;
    @(negedge CLK);
    check_bit({name, " done one cycle"}, 1'b0, done);
    check_bit({name, " busy after done"}, 1'b0, busy);
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_reset();
    RST = 1'b1;
    repeat (16) begin
      @(negedge CLK);
      check_idle("reset held");
    end
    @(posedge CLK);
    #10;
    RST = 1'b0;
    repeat (2) begin
      @(negedge CLK);
      check_idle("reset released");
    end
  endtask

  // Both sides of every breakpoint, extremes and mirrors
  task automatic test_segments();
    int mags [12] = '{0, 1, 4095, 4096, 4097, 9727, 9728, 9729,
                      20479, 20480, 20481, 32767};
    stim.delete();
    foreach (mags[k]) begin
      stim.push_back(fix_t'(mags[k]));
      stim.push_back(fix_t'(-mags[k]));
    end
    stim.push_back(fix_t'(-32768));
    run_matrix("segments", 8'd1, dim_t'(stim.size()), 1'b0, 1'b0);
  endtask

  task automatic test_matrix_order();
    fill_random(35);
    run_matrix("matrix_order", 8'd5, 8'd7, 1'b0, 1'b0);
  endtask

  task automatic test_backpressure();
    fill_random(36);
    run_matrix("backpressure", 8'd6, 8'd6, 1'b1, 1'b0);
  endtask

  task automatic test_start_rules();
    @(posedge CLK);
    #10;
    size_i = 8'd0;
    size_j = 8'd4;
    start = 1'b1;
    @(posedge CLK);
    #10;
    size_i = 8'd3;
    size_j = 8'd0;
    @(posedge CLK);
    #10;
    start = 1'b0;
    repeat (3) begin
      @(negedge CLK);
      check_idle("start_rules zero size");
    end
    fill_random(6);
    run_matrix("start_rules restart", 8'd2, 8'd3, 1'b0, 1'b1);
    fill_random(12);
    run_matrix("start_rules second", 8'd4, 8'd3, 1'b0, 1'b0);
  endtask

  initial begin
    void'($urandom(79));
    error_count = 0;
    CLK = 1'b0;
    RST = 1'b1;
    start = 1'b0;
    size_i = '0;
    size_j = '0;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b0;
    test_reset();
    test_segments();
    test_matrix_order();
    test_backpressure();
    test_start_rules();
    $display("errors counted: %0d", error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== test/matrix_logistic_assert.sv ====
/*
  Concurrent checks on output handshake, done pulse and reset
  Bound into the top level
*/

module matrix_logistic_assert (
  input logic               CLK,
  input logic               RST,
  input logic               busy,
  input logic               in_ready,
  input logic               out_valid,
  input logic               out_ready,
  input logistic_pkg::fix_t out_data,
  input logic               done
);
  timeunit 1ns;
  timeprecision 100ps;

  // Output held until taken
  assert property (@(posedge CLK) disable iff (RST)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("output changed while out_ready was low");

  // Single-cycle done
  assert property (@(posedge CLK) disable iff (RST) done |=> !done)
    else $error("done lasted more than one cycle");

  assert property (@(posedge CLK) RST |-> !in_ready && !out_valid && !busy)
    else $error("handshake or busy active during reset");

endmodule

bind matrix_logistic_top matrix_logistic_assert i_assert (
  .CLK       (CLK),
  .RST       (RST),
  .busy      (busy),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data),
  .done      (done)
);

// ==== verilog/matrix_logistic_top.sv ====
/*
  Matrix logistic-function unit, top level
*/

module matrix_logistic_top (
  input  logic               CLK,
  input  logic               RST,
  input  logic               start,
  input  matrix_pkg::dim_t   size_i,
  input  matrix_pkg::dim_t   size_j,
  output logic               busy,
  input  logic               in_valid,
  output logic               in_ready,
  input  logistic_pkg::fix_t in_data,
  output logic               out_valid,
  input  logic               out_ready,
  output logistic_pkg::fix_t out_data,
  output matrix_pkg::dim_t   out_row,
  output matrix_pkg::dim_t   out_col,
  output logic               out_row_last,
  output logic               out_last,
  output logic               done
);
  import logistic_pkg::*;

  // Sequencer to pipeline
  logic elem_valid;
  logic elem_ready;
  fix_t elem_data;

  // Pipeline to combiner
  logic res_valid;
  logic res_ready;
  fix_t res_data;

  // Element tags
  tag_if tag_bus ();

  matrix_sequencer i_sequencer (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .size_i     (size_i),
    .size_j     (size_j),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .elem_valid (elem_valid),
    .elem_ready (elem_ready),
    .elem_data  (elem_data),
    .tag        (tag_bus.src),
    // Done doubles as the end-of-matrix notice
    .done_seen  (done),
    .busy       (busy)
  );

  plan_logistic i_logistic (
    .CLK        (CLK),
    .RST        (RST),
    .elem_valid (elem_valid),
    .elem_ready (elem_ready),
    .elem_data  (elem_data),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_data   (res_data)
  );

  result_combiner i_combiner (
    .CLK          (CLK),
    .RST          (RST),
    .tag          (tag_bus.dst),
    .res_valid    (res_valid),
    .res_ready    (res_ready),
    .res_data     (res_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_row      (out_row),
    .out_col      (out_col),
    .out_row_last (out_row_last),
    .out_last     (out_last),
    .done         (done)
  );

endmodule

// ==== verilog/result_combiner.sv ====
/*
  Tag FIFO and pairing of tags with sigmoid results
  Output register and done pulse
*/

module result_combiner (
  input  logic               CLK,
  input  logic               RST,
  tag_if.dst                 tag,
  input  logic               res_valid,
  output logic               res_ready,
  input  logistic_pkg::fix_t res_data,
  output logic               out_valid,
  input  logic               out_ready,
  output logistic_pkg::fix_t out_data,
  output matrix_pkg::dim_t   out_row,
  output matrix_pkg::dim_t   out_col,
  output logic               out_row_last,
  output logic               out_last,
  output logic               done
);
  import matrix_pkg::*;

  localparam int PTR_W = $clog2(TAG_DEPTH);

  // Tag storage
  dim_t             fifo_row [TAG_DEPTH];
  dim_t             fifo_col [TAG_DEPTH];
  logic [TAG_DEPTH-1:0] fifo_row_last;
  logic [TAG_DEPTH-1:0] fifo_mat_last;

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  logic push;
  logic pop;
  logic out_free;

  ////////////////////
  // Tag FIFO
  ////////////////////

  assign tag.ready = (count != (PTR_W+1)'(TAG_DEPTH));
  assign push      = tag.valid && tag.ready;

  always_ff @(posedge CLK) begin
    if (push) begin
      fifo_row[wr_ptr]      <= tag.row;
      fifo_col[wr_ptr]      <= tag.col;
      fifo_row_last[wr_ptr] <= tag.row_last;
      fifo_mat_last[wr_ptr] <= tag.mat_last;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      // Push and pop together leave count as is
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////
  // Pairing and output
  ////////////////////

  // Output register empty or handing over this cycle
  assign out_free  = !out_valid || out_ready;
  // Tag enters the FIFO on the edge its element enters the pipeline
  assign res_ready = out_free;
  assign pop       = res_valid && res_ready;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      if (out_free) begin
        out_valid <= pop;
      end
      // One cycle after the last result leaves
      done <= out_valid && out_ready && out_last;
    end
  end

  always_ff @(posedge CLK) begin
    if (pop) begin
      out_data     <= res_data;
      out_row      <= fifo_row[rd_ptr];
      out_col      <= fifo_col[rd_ptr];
      out_row_last <= fifo_row_last[rd_ptr];
      out_last     <= fifo_mat_last[rd_ptr];
    end
  end

endmodule

// ==== verilog/plan_logistic.sv ====
/*
  Two-stage PLAN sigmoid pipeline, Q3.12 in and out
  Stage 1 picks |x| and segment, stage 2 shifts, adds and mirrors
*/

module plan_logistic (
  input  logic               CLK,
  input  logic               RST,
  input  logic               elem_valid,
  output logic               elem_ready,
  input  logistic_pkg::fix_t elem_data,
  output logic               res_valid,
  input  logic               res_ready,
  output logistic_pkg::fix_t res_data
);
  import logistic_pkg::*;

  // Stage 1 registers
  logic s1_valid;
  fix_t s1_abs;
  logic s1_neg;
  seg_e s1_seg;

  // Stage 2 registers
  logic s2_valid;
  fix_t s2_data;

  // Combinational stage inputs
  fix_t abs_x;
  seg_e seg_x;
  fix_t y_pos;
  fix_t y_out;

  logic s2_adv;

  ////////////////////
  // Stall control
  ////////////////////

  // A stage moves when the next one is empty or draining
  assign s2_adv     = !s2_valid || res_ready;
  assign elem_ready = !s1_valid || s2_adv;

  ////////////////////
  // Stage 1
  ////////////////////

  always_comb begin
    // |-32768| saturates to 32767
    if (elem_data[FIX_W-1] && (elem_data[FIX_W-2:0] == '0)) begin
      abs_x = {1'b0, {(FIX_W-1){1'b1}}};
    end else if (elem_data[FIX_W-1]) begin
      abs_x = -elem_data;
    end else begin
      abs_x = elem_data;
    end

    // Breakpoint compare on |x|
    if (abs_x < BRK_1) begin
      seg_x = SEG_QUARTER;
    end else if (abs_x < BRK_2) begin
      seg_x = SEG_EIGHTH;
    end else if (abs_x < BRK_3) begin
      seg_x = SEG_THIRTYSECOND;
    end else begin
      seg_x = SEG_SAT;
    end
  end

  ////////////////////
  // Stage 2
  ////////////////////

  always_comb begin
    // |x| is never negative, so >> acts as a plain truncating shift
    case (s1_seg)
      SEG_QUARTER:      y_pos = (s1_abs >> 2) + OFS_0;
      SEG_EIGHTH:       y_pos = (s1_abs >> 3) + OFS_1;
      SEG_THIRTYSECOND: y_pos = (s1_abs >> 5) + OFS_2;
      default:          y_pos = ONE_FIX;
    endcase
    // sigmoid(-x) = 1 - sigmoid(x)
    y_out = s1_neg ? (ONE_FIX - y_pos) : y_pos;
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (elem_ready) begin
        s1_valid <= elem_valid;
      end
      if (s2_adv) begin
        s2_valid <= s1_valid;
      end
    end
  end

  // Payload
  always_ff @(posedge CLK) begin
    if (elem_valid && elem_ready) begin
      s1_abs <= abs_x;
      s1_neg <= elem_data[FIX_W-1];
      s1_seg <= seg_x;
    end
    if (s1_valid && s2_adv) begin
      s2_data <= y_out;
    end
  end

  assign res_valid = s2_valid;
  assign res_data  = s2_data;

endmodule

// ==== verilog/matrix_sequencer.sv ====
/*
  Start/size control FSM for one matrix
  Element acceptance, row-major i/j counting and tag generation
*/

module matrix_sequencer (
  input  logic               CLK,
  input  logic               RST,
  input  logic               start,
  input  matrix_pkg::dim_t   size_i,
  input  matrix_pkg::dim_t   size_j,
  input  logic               in_valid,
  output logic               in_ready,
  input  logistic_pkg::fix_t in_data,
  output logic               elem_valid,
  input  logic               elem_ready,
  output logistic_pkg::fix_t elem_data,
  tag_if.src                 tag,
  input  logic               done_seen,
  output logic               busy
);
  import matrix_pkg::*;

  seq_state_e state;

  // Latched sizes and current position
  dim_t size_i_q;
  dim_t size_j_q;
  dim_t row_q;
  dim_t col_q;

  logic run;
  logic accept;
  logic row_last;
  logic mat_last;

  ////////////////////
  // Element path
  ////////////////////

  assign run = (state == SEQ_RUN);

  // Pipeline and tag FIFO must both take the element
  assign in_ready = run && elem_ready && tag.ready;
  assign accept   = in_valid && in_ready;

  // Each side qualified by the other side's ready
  assign elem_valid = in_valid && run && tag.ready;
  assign elem_data  = in_data;

  assign row_last = (col_q == dim_t'(size_j_q - 1'b1));
  assign mat_last = row_last && (row_q == dim_t'(size_i_q - 1'b1));

  // Tag of the element now on the input
  assign tag.valid    = in_valid && run && elem_ready;
  assign tag.row      = row_q;
  assign tag.col      = col_q;
  assign tag.row_last = row_last;
  assign tag.mat_last = mat_last;

  // Drops together with the done pulse
  assign busy = (state != SEQ_IDLE) && !done_seen;

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= SEQ_IDLE;
      size_i_q <= '0;
      size_j_q <= '0;
      row_q    <= '0;
      col_q    <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          // Zero sizes never start a matrix
          if (start && (size_i != '0) && (size_j != '0)) begin
            size_i_q <= size_i;
            size_j_q <= size_j;
            row_q    <= '0;
            col_q    <= '0;
            state    <= SEQ_RUN;
          end
        end
        SEQ_RUN: begin
          if (accept) begin
            if (row_last) begin
              col_q <= '0;
              row_q <= row_q + 1'b1;
            end else begin
              col_q <= col_q + 1'b1;
            end
            // Last element taken, wait for the results
            if (mat_last) begin
              state <= SEQ_DRAIN;
            end
          end
        end
        SEQ_DRAIN: begin
          if (done_seen) begin
            state <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/tag_if.sv ====
/*
  Element tag stream, sequencer to combiner
*/

interface tag_if;
  import matrix_pkg::*;

  // Handshake
  logic valid;
  logic ready;

  // Tag payload
  dim_t row;
  dim_t col;
  logic row_last;
  logic mat_last;

  modport src (output valid, output row, output col, output row_last,
               output mat_last, input ready);

  modport dst (input valid, input row, input col, input row_last,
               input mat_last, output ready);

endinterface

// ==== verilog/matrix_pkg.sv ====
/*
  Matrix dimension type and sequencer FSM states
  Depth of the tag FIFO in the combiner
*/

package matrix_pkg;

  //////////////////////
  // Dimensions
  //////////////////////

  // Row/column index and size, valid sizes 1..255
  localparam int DIM_W = 8;

  typedef logic [DIM_W-1:0] dim_t;

  //////////////////////
  // Control
  //////////////////////

  // Sequencer FSM
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_DRAIN
  } seq_state_e;

  // Enough for three items in flight plus one
  localparam int TAG_DEPTH = 4;

endpackage

// ==== verilog/logistic_pkg.sv ====
/*
  Fixed-point format for the logistic datapath
  PLAN breakpoints, segment offsets and the segment enum
*/

package logistic_pkg;

  //////////////////////
  // Data format
  //////////////////////

  // Q3.12 signed word
  localparam int FIX_W     = 16;
  localparam int FRAC_BITS = 12;

  typedef logic signed [FIX_W-1:0] fix_t;

  // 1.0 in Q3.12
  localparam fix_t ONE_FIX = fix_t'(1 << FRAC_BITS);

  //////////////////////
  // PLAN constants
  //////////////////////

  // Breakpoints 1.0, 2.375 and 5.0
  localparam fix_t BRK_1 = ONE_FIX;
  localparam fix_t BRK_2 = 16'sd9728;
  localparam fix_t BRK_3 = 16'sd20480;

  // Offsets 0.5, 0.625 and 0.84375
  localparam fix_t OFS_0 = 16'sd2048;
  localparam fix_t OFS_1 = 16'sd2560;
  localparam fix_t OFS_2 = 16'sd3456;

  // Segment picked in stage 1, used as stage-2 opcode
  typedef enum logic [1:0] {
    SEG_QUARTER,
    SEG_EIGHTH,
    SEG_THIRTYSECOND,
    SEG_SAT
  } seg_e;

endpackage
